//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = lsuTb
FILELIST = verilog.f

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- src/busPkg.sv
// wishbone classic bus types

`default_nettype none

`include "lsu_cfg.svh"

package busPkg;

  // signals driven by the master
  // cyc and stb always move together since only single transfers are issued
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`LSU_XLEN/8-1:0]  sel;
    logic [`LSU_XLEN-1:0]    adr;
    logic [`LSU_XLEN-1:0]    dat;
  } wbM2s_t;

  // signals driven by the slave
  // dat is only meaningful in the cycle where ack is high on a read
  typedef struct packed {
    logic                  ack;
    logic [`LSU_XLEN-1:0]  dat;
  } wbS2m_t;

endpackage

`default_nettype wire

//--- src/dtim.sv
// tightly integrated data memory

`default_nettype none

`include "lsu_cfg.svh"

module dtim (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                en,
  input  logic                                we,
  input  logic [$clog2(`LSU_DTIM_WORDS)-1:0]  wordAdr,
  input  logic [`LSU_XLEN/8-1:0]              byteMask,
  input  logic [`LSU_XLEN-1:0]                wdata,
  output logic [`LSU_XLEN-1:0]                rdata
);

  localparam int NumBytes = `LSU_XLEN / 8;

  logic [`LSU_XLEN-1:0] mem [`LSU_DTIM_WORDS];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  // each byte lane has its own enable so subword stores leave
  // the neighbouring bytes of the word untouched
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (byteMask[b]) begin
          mem[wordAdr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // the read is registered, giving one cycle of latency
  // rdata holds its value until the next read so the response
  // can be formed in the cycle after the access
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdata <= '0;
    end else if (en && !we) begin
      rdata <= mem[wordAdr];
    end
  end

endmodule

`default_nettype wire

//--- src/loadExtract.sv
// load subword extraction

`default_nettype none

`include "lsu_cfg.svh"

module loadExtract import lsuPkg::*; (
  input  logic [2:0]            funct3,
  input  logic [1:0]            byteOffset,
  input  logic [`LSU_XLEN-1:0]  readWord,
  output logic [`LSU_XLEN-1:0]  loadData
);

  logic [7:0]  byteSel;
  logic [15:0] halfSel;
  logic        zeroExt;

  // funct3 bit 2 marks the unsigned loads lbu and lhu
  assign zeroExt = funct3[2];

  ////////////////////////////////////////////////////////////
  // subword select
  ////////////////////////////////////////////////////////////

  // pick the addressed byte lane of the little-endian word
  always_comb begin
    case (byteOffset)
      2'd0:    byteSel = readWord[7:0];
      2'd1:    byteSel = readWord[15:8];
      2'd2:    byteSel = readWord[23:16];
      default: byteSel = readWord[31:24];
    endcase
  end

  // halfwords are aligned, so only offset bit 1 matters here
  assign halfSel = byteOffset[1] ? readWord[31:16] : readWord[15:0];

  ////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////

  // fill the upper bits with zeros or with copies of the subword's top bit
  always_comb begin
    case (accSize_t'(funct3[1:0]))
      sizeByte: begin
        loadData = {{(`LSU_XLEN-8){~zeroExt & byteSel[7]}}, byteSel};
      end
      sizeHalf: begin
        loadData = {{(`LSU_XLEN-16){~zeroExt & halfSel[15]}}, halfSel};
      end
      default: begin
        loadData = readWord;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/lsu.sv
// load/store unit top level

`default_nettype none

`include "lsu_cfg.svh"

module lsu import lsuPkg::*, busPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  // core side
  input  lsuReq_t req,
  input  logic    reqValid,
  output logic    reqReady,
  output lsuRsp_t rsp,
  output logic    rspValid,
  // external Wishbone side
  output wbM2s_t  wbOut,
  input  wbS2m_t  wbIn
);

  localparam int DtimAdrBits = $clog2(`LSU_DTIM_WORDS);
  localparam logic [`LSU_XLEN-1:0] DtimLast = `LSU_DTIM_BASE + (`LSU_DTIM_WORDS * 4) - 1;

  typedef enum logic [1:0] {stIdle, stDtim, stBus} lsuState_t;

  // attributes worked out from a request as it is accepted
  typedef struct packed {
    logic loadMis;
    logic storeMis;
    logic accFault;
    logic toBus;
  } reqDecode_t;

  lsuState_t  state;
  lsuReq_t    reqReg;
  reqDecode_t dec;
  reqDecode_t decReg;

  logic accept;
  logic quickRsp;
  logic misaligned;
  logic isAccess;
  logic rspPulse;
  logic busStart;
  logic busDone;
  logic anyFault;

  logic [`LSU_XLEN-1:0]    laneData;
  logic [`LSU_XLEN/8-1:0]  byteMask;
  logic [`LSU_XLEN-1:0]    dtimOffset;
  logic [`LSU_XLEN-1:0]    dtimRdata;
  logic [`LSU_XLEN-1:0]    busRdata;
  logic [`LSU_XLEN-1:0]    readWord;
  logic [`LSU_XLEN-1:0]    loadData;

  ////////////////////////////////////////////////////////////
  // request decode and fault check
  ////////////////////////////////////////////////////////////

  // a halfword needs an even address and a word needs one divisible by four
  always_comb begin
    isAccess = (req.op == memRead) || (req.op == memWrite);
    case (accSize_t'(req.funct3[1:0]))
      sizeByte: misaligned = 1'b0;
      sizeHalf: misaligned = req.adr[0];
      default:  misaligned = |req.adr[1:0];
    endcase
    dec.loadMis  = (req.op == memRead) & misaligned;
    dec.storeMis = (req.op == memWrite) & misaligned;
    dec.toBus    = (req.adr >= `LSU_BUS_BASE) && (req.adr <= `LSU_BUS_LIMIT);
    dec.accFault = isAccess & ~dec.toBus &
                   ~((req.adr >= `LSU_DTIM_BASE) && (req.adr <= DtimLast));
  end

  // faults and empty requests answer at once and touch neither target
  assign quickRsp = ~isAccess | misaligned | dec.accFault;
  assign accept   = reqValid & reqReady;

  // ready while idle, and again in the cycle the bus answer comes back
  assign reqReady = (state == stIdle) | ((state == stBus) & busDone);

  ////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////

  // rspPulse covers quick answers and the cycle after the DTIM access
  // the bus answer instead rides on the master's done pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= stIdle;
      rspPulse <= 1'b0;
      busStart <= 1'b0;
    end else begin
      rspPulse <= (accept & quickRsp) | (state == stDtim);
      busStart <= accept & ~quickRsp & dec.toBus;
      if (accept) begin
        if (quickRsp) begin
          state <= stIdle;
        end else if (dec.toBus) begin
          state <= stBus;
        end else begin
          state <= stDtim;
        end
      end else if ((state == stDtim) || busDone) begin
        state <= stIdle;
      end
    end
  end

  // the accepted request stays here until the next one is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      reqReg <= req;
      decReg <= dec;
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath and targets
  ////////////////////////////////////////////////////////////

  storeAlign storeAlign_i (
    .funct3     (reqReg.funct3),
    .byteOffset (reqReg.adr[1:0]),
    .wdata      (reqReg.wdata),
    .laneData   (laneData),
    .byteMask   (byteMask)
  );

  // word index inside the DTIM region
  assign dtimOffset = reqReg.adr - `LSU_DTIM_BASE;

  dtim dtim_i (
    .clk      (clk),
    .rstN     (rstN),
    .en       (state == stDtim),
    .we       (reqReg.op == memWrite),
    .wordAdr  (dtimOffset[2 +: DtimAdrBits]),
    .byteMask (byteMask),
    .wdata    (laneData),
    .rdata    (dtimRdata)
  );

  wbMaster wbMaster_i (
    .clk   (clk),
    .rstN  (rstN),
    .start (busStart),
    .we    (reqReg.op == memWrite),
    .adr   (reqReg.adr),
    .sel   (byteMask),
    .wdata (laneData),
    .wbOut (wbOut),
    .wbIn  (wbIn),
    .done  (busDone),
    .rdata (busRdata)
  );

  // the region decided at acceptance picks the word to extract
  assign readWord = decReg.toBus ? busRdata : dtimRdata;

  loadExtract loadExtract_i (
    .funct3     (reqReg.funct3),
    .byteOffset (reqReg.adr[1:0]),
    .readWord   (readWord),
    .loadData   (loadData)
  );

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  assign anyFault = decReg.loadMis | decReg.storeMis | decReg.accFault;

  // load data is only returned for a clean read, stores answer with zero
  always_comb begin
    rsp.rdata           = ((reqReg.op == memRead) && !anyFault) ? loadData : '0;
    rsp.loadMisaligned  = decReg.loadMis;
    rsp.storeMisaligned = decReg.storeMis;
    rsp.accessFault     = decReg.accFault;
  end

  assign rspValid = rspPulse | busDone;

endmodule

`default_nettype wire

//--- src/lsuPkg.sv
// core-side load/store types

`default_nettype none

`include "lsu_cfg.svh"

package lsuPkg;

  // memory operation of a request
  // read sits in the high bit and write in the low bit, as on the core's MemRW lines
  typedef enum logic [1:0] {
    memNone  = 2'b00,
    memWrite = 2'b01,
    memRead  = 2'b10
  } memOp_t;

  // access size, taken from the low two bits of funct3
  // funct3 bit 2 separately selects zero extension on loads
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } accSize_t;

  // one load or store as issued by the core
  typedef struct packed {
    memOp_t                op;
    logic [2:0]            funct3;
    logic [`LSU_XLEN-1:0]  adr;
    logic [`LSU_XLEN-1:0]  wdata;
  } lsuReq_t;

  // result returned with the one-cycle response pulse
  // rdata already holds the extended load value
  typedef struct packed {
    logic [`LSU_XLEN-1:0]  rdata;
    logic                  loadMisaligned;
    logic                  storeMisaligned;
    logic                  accessFault;
  } lsuRsp_t;

endpackage

`default_nettype wire

//--- src/lsu_cfg.svh
// load/store unit configuration

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// width of a data word and of every address
`define LSU_XLEN 32

// depth of the tightly integrated data memory, counted in words
`define LSU_DTIM_WORDS 256

// byte base address of the DTIM region
// the region spans LSU_DTIM_WORDS words starting here, so the base must be word aligned
`define LSU_DTIM_BASE 32'h8000_0000

// bounds of the external Wishbone region, both inclusive
// any address that lands in neither region raises an access fault
`define LSU_BUS_BASE 32'h1000_0000
`define LSU_BUS_LIMIT 32'h1000_FFFF

`endif

//--- src/storeAlign.sv
// store lane replication and byte mask

`default_nettype none

`include "lsu_cfg.svh"

module storeAlign import lsuPkg::*; (
  input  logic [2:0]                funct3,
  input  logic [1:0]                byteOffset,
  input  logic [`LSU_XLEN-1:0]      wdata,
  output logic [`LSU_XLEN-1:0]      laneData,
  output logic [`LSU_XLEN/8-1:0]    byteMask
);

  localparam int NumBytes = `LSU_XLEN / 8;
  localparam int NumHalves = `LSU_XLEN / 16;

  ////////////////////////////////////////////////////////////
  // lane data
  ////////////////////////////////////////////////////////////

  // the low byte or halfword is copied onto every lane
  // so the memory only needs the mask to pick the right one
  // a word goes out unchanged
  always_comb begin
    case (accSize_t'(funct3[1:0]))
      sizeByte: laneData = {NumBytes{wdata[7:0]}};
      sizeHalf: laneData = {NumHalves{wdata[15:0]}};
      default:  laneData = wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // byte mask
  ////////////////////////////////////////////////////////////

  // a byte enables the one lane picked by the offset
  // a halfword enables the low or high pair, chosen by offset bit 1
  // the misalignment check upstream keeps offset bit 0 clear for halfwords
  always_comb begin
    case (accSize_t'(funct3[1:0]))
      sizeByte: begin
        byteMask = 4'b0001 << byteOffset;
      end
      sizeHalf: begin
        byteMask = byteOffset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // full word, and anything wider is treated the same
        byteMask = '1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/wbMaster.sv
// wishbone classic bus master

`default_nettype none

`include "lsu_cfg.svh"

module wbMaster import busPkg::*; (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        start,
  input  logic                        we,
  input  logic [`LSU_XLEN-1:0]        adr,
  input  logic [`LSU_XLEN/8-1:0]      sel,
  input  logic [`LSU_XLEN-1:0]        wdata,
  output wbM2s_t                      wbOut,
  input  wbS2m_t                      wbIn,
  output logic                        done,
  output logic [`LSU_XLEN-1:0]        rdata
);

  // high while a transfer is on the bus, drives both cyc and stb
  logic active;
  logic ackSeen;

  // transfer attributes, held stable until the slave acknowledges
  logic                    weReg;
  logic [`LSU_XLEN-1:0]    adrReg;
  logic [`LSU_XLEN/8-1:0]  selReg;
  logic [`LSU_XLEN-1:0]    datReg;

  // ack only counts while our own cycle is open
  assign ackSeen = active & wbIn.ack;

  ////////////////////////////////////////////////////////////
  // bus cycle control
  ////////////////////////////////////////////////////////////

  // cyc and stb rise on the edge after start and fall on the
  // edge where ack is sampled, so done lands one cycle after ack
  // the requester never pulses start while a transfer is open
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      active <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= ackSeen;
      if (start) begin
        active <= 1'b1;
      end else if (ackSeen) begin
        active <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (start) begin
      weReg  <= we;
      adrReg <= adr;
      selReg <= sel;
      datReg <= wdata;
    end
    // the whole bus word is kept and the subword is picked later
    if (ackSeen) begin
      rdata <= wbIn.dat;
    end
  end

  always_comb begin
    wbOut.cyc = active;
    wbOut.stb = active;
    wbOut.we  = weReg;
    wbOut.sel = selReg;
    wbOut.adr = adrReg;
    wbOut.dat = datReg;
  end

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
// testbench clock and reset

`default_nettype none

module clockGen (
  output logic clk,
  output logic rstN
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ResetCycles = 16;

  // free running 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset is released on a rising edge after the hold time
  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/lsuTb.sv
// load/store unit testbench

`default_nettype none

`include "lsu_cfg.svh"

module lsuTb import lsuPkg::*, busPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // 680 transactions at a worst case of 13 cycles each take under 9000 cycles
  // the limit doubles that with room to spare
  localparam int CycleLimit = 20000;
  localparam int RspLimit = 40;

  logic        clk;
  logic        rstN;
  lsuReq_t     req;
  logic        reqValid;
  logic        reqReady;
  lsuRsp_t     rsp;
  logic        rspValid;
  wbM2s_t      wbOut;
  wbS2m_t      wbIn;
  logic [2:0]  waitCycles;
  logic [31:0] lcgState;
  logic [31:0] lastAdr;
  int          cycleCount;

  // reference bytes of both regions
  logic [7:0] refDtim [`LSU_DTIM_WORDS * 4];
  logic [7:0] refBus [65536];

  clockGen clkGen (.clk(clk), .rstN(rstN));

  wbSlaveModel busSlave (
    .clk(clk), .rstN(rstN), .wbIn(wbOut), .wbOut(wbIn), .waitCycles(waitCycles)
  );

  lsu lsu_i (
    .clk(clk), .rstN(rstN), .req(req), .reqValid(reqValid), .reqReady(reqReady),
    .rsp(rsp), .rspValid(rspValid), .wbOut(wbOut), .wbIn(wbIn)
  );

  //////////////////////////////////////////////////////////////
  // failure reporting and checks
  //////////////////////////////////////////////////////////////

  task automatic endFailed();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic failNow(input string msg);
    $display("Error: %s", msg);
    endFailed();
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      endFailed();
    end
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CycleLimit) begin
      failNow("the run went past its cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic inDtim(input logic [31:0] a);
    return (a >= `LSU_DTIM_BASE) && (a < `LSU_DTIM_BASE + `LSU_DTIM_WORDS * 4);
  endfunction

  function automatic logic inBus(input logic [31:0] a);
    return (a >= `LSU_BUS_BASE) && (a <= `LSU_BUS_LIMIT);
  endfunction

  function automatic logic [7:0] readByte(input logic [31:0] a);
    logic [31:0] off;
    off = inDtim(a) ? a - `LSU_DTIM_BASE : a - `LSU_BUS_BASE;
    return inDtim(a) ? refDtim[off[9:0]] : refBus[off[15:0]];
  endfunction

  task automatic writeByte(input logic [31:0] a, input logic [7:0] d);
    logic [31:0] off;
    off = inDtim(a) ? a - `LSU_DTIM_BASE : a - `LSU_BUS_BASE;
    if (inDtim(a)) begin
      refDtim[off[9:0]] = d;
    end else begin
      refBus[off[15:0]] = d;
    end
  endtask

  function automatic logic [31:0] readWord(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return {readByte(w + 3), readByte(w + 2), readByte(w + 1), readByte(w)};
  endfunction

  // lb/lh sign extend, lbu/lhu zero extend, lw takes the whole word
  function automatic logic [31:0] expLoad(input logic [2:0] f3, input logic [31:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = readByte(a);
    h = {readByte(a + 1), readByte(a)};
    case (f3[1:0])
      2'b00: return f3[2] ? {24'h0, b} : {{24{b[7]}}, b};
      2'b01: return f3[2] ? {16'h0, h} : {{16{h[15]}}, h};
      default: return readWord(a);
    endcase
  endfunction

  function automatic logic [3:0] expMask(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
      2'b00: return 4'b0001 << off;
      2'b01: return 4'b0011 << off;
      default: return 4'b1111;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////
  // one access with all of its checks
  //////////////////////////////////////////////////////////////

  task automatic doAccess(input memOp_t op, input logic [2:0] f3, input logic [31:0] adr,
                          input logic [31:0] wdata);
    logic        mis;
    logic        fault;
    logic        toBus;
    logic        busOk;
    logic        ackPrev;
    logic        expRsp;
    logic        expCyc;
    logic [3:0]  mask;
    logic [31:0] laneMask;
    logic [31:0] laneExp;
    logic [31:0] expData;
    logic [31:0] r;
    int          waitCount;
    int          quickLat;
    mis = ((f3[1:0] == 2'b01) && adr[0]) || ((f3[1:0] == 2'b10) && (adr[1:0] != 2'b00));
    toBus = inBus(adr);
    fault = !toBus && !inDtim(adr);
    busOk = toBus && !mis;
    // faults answer in the first cycle after acceptance and DTIM accesses in the second
    quickLat = (mis || fault) ? 1 : 2;
    mask = expMask(f3, adr[1:0]);
    laneMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    // store bytes move up to the lanes picked by the address offset
    laneExp = wdata << (8 * adr[1:0]);
    expData = ((op == memRead) && !mis && !fault) ? expLoad(f3, adr) : 32'h0;
    ackPrev = 1'b0;
    r = lcgNext();
    @(posedge clk);
    req <= '{op: op, funct3: f3, adr: adr, wdata: wdata};
    reqValid <= 1'b1;
    waitCycles <= r[18:16];
    @(negedge clk);
    if (!reqReady) begin
      failNow("the unit was not ready while idle");
    end
    checkEq("rspValid", 32'(rspValid), 32'h0);
    @(posedge clk);
    reqValid <= 1'b0;
    waitCount = 0;
    do begin
      @(negedge clk);
      waitCount++;
      if (waitCount > RspLimit) begin
        failNow("no response arrived within 40 cycles");
      end
      // a bus answer follows the edge that samples ack
      expRsp = busOk ? ackPrev : (waitCount == quickLat);
      // cyc and stb rise one cycle after acceptance and drop once ack is sampled
      expCyc = busOk && (waitCount >= 2) && !ackPrev;
      checkEq("rspValid", 32'(rspValid), 32'(expRsp));
      checkEq("wbOut.cyc", 32'(wbOut.cyc), 32'(expCyc));
      checkEq("wbOut.stb", 32'(wbOut.stb), 32'(expCyc));
      if (wbOut.cyc) begin
        checkEq("wbOut.adr", wbOut.adr, adr);
        checkEq("wbOut.sel", 32'(wbOut.sel), 32'(mask));
        checkEq("wbOut.we", 32'(wbOut.we), 32'(op == memWrite));
        if (op == memWrite) begin
          checkEq("wbOut.dat", wbOut.dat & laneMask, laneExp & laneMask);
        end
      end
      if (!rspValid) begin
        checkEq("reqReady", 32'(reqReady), 32'h0);
      end
      ackPrev = wbIn.ack;
    end while (!rspValid);
    checkEq("rsp.rdata", rsp.rdata, expData);
    checkEq("rsp.loadMisaligned", 32'(rsp.loadMisaligned), 32'((op == memRead) && mis));
    checkEq("rsp.storeMisaligned", 32'(rsp.storeMisaligned), 32'((op == memWrite) && mis));
    checkEq("rsp.accessFault", 32'(rsp.accessFault), 32'(fault));
    if ((op == memWrite) && !mis && !fault) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          writeByte({adr[31:2], 2'b00} + 32'(b), laneExp[8*b +: 8]);
        end
      end
    end
    // the slave word must match the reference after any bus side access
    if (toBus) begin
      checkEq("slave memory", busSlave.mem[adr[15:2]], readWord(adr));
    end
  endtask

  // random size and aligned offset in one region
  task automatic randAccess(input logic busSide, input memOp_t op);
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [1:0]  off;
    r = lcgNext();
    s = lcgNext();
    case (s[25:24])
      2'd0: begin
        f3 = 3'b000;
        off = s[27:26];
      end
      2'd1: begin
        f3 = 3'b001;
        off = {s[26], 1'b0};
      end
      default: begin
        f3 = 3'b010;
        off = 2'b00;
      end
    endcase
    if ((op == memRead) && (f3 != 3'b010)) begin
      f3[2] = s[28];
    end
    if (busSide) begin
      lastAdr = `LSU_BUS_BASE + {16'h0, r[29:16], off};
    end else begin
      lastAdr = `LSU_DTIM_BASE + {22'h0, r[23:16], off};
    end
    doAccess(op, f3, lastAdr, lcgNext());
  endtask

  //////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////

  task automatic resetTest();
    @(negedge clk);
    checkEq("rspValid", 32'(rspValid), 32'h0);
    checkEq("wbOut.cyc", 32'(wbOut.cyc), 32'h0);
    checkEq("wbOut.stb", 32'(wbOut.stb), 32'h0);
    checkEq("reqReady", 32'(reqReady), 32'h1);
  endtask

  task automatic dtimLoadTest();
    logic [31:0] a;
    for (int i = 0; i < `LSU_DTIM_WORDS; i++) begin
      doAccess(memWrite, 3'b010, `LSU_DTIM_BASE + 32'(4 * i), lcgNext());
    end
    for (int i = 0; i < 8; i++) begin
      a = `LSU_DTIM_BASE + 32'(4 * i);
      for (int o = 0; o < 4; o++) begin
        doAccess(memRead, 3'b000, a + 32'(o), 32'h0);
        doAccess(memRead, 3'b100, a + 32'(o), 32'h0);
      end
      for (int o = 0; o < 4; o += 2) begin
        doAccess(memRead, 3'b001, a + 32'(o), 32'h0);
        doAccess(memRead, 3'b101, a + 32'(o), 32'h0);
      end
    end
  endtask

  task automatic dtimStoreTest();
    logic [31:0] a;
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      a = `LSU_DTIM_BASE + 32'(4 * i);
      r = lcgNext();
      doAccess(memWrite, 3'b000, a + {30'h0, r[17:16]}, lcgNext());
      doAccess(memWrite, 3'b001, a + {30'h0, r[18], 1'b0}, lcgNext());
      doAccess(memRead, 3'b010, a, 32'h0);
    end
  endtask

  task automatic busTest();
    for (int i = 0; i < 24; i++) begin
      randAccess(1'b1, memWrite);
      doAccess(memRead, 3'b010, {lastAdr[31:2], 2'b00}, 32'h0);
      randAccess(1'b1, memRead);
    end
  endtask

  task automatic faultTest();
    doAccess(memRead, 3'b001, `LSU_DTIM_BASE + 32'h1, 32'h0);
    doAccess(memWrite, 3'b001, `LSU_DTIM_BASE + 32'h3, 32'hdead_beef);
    doAccess(memRead, 3'b010, `LSU_DTIM_BASE + 32'h2, 32'h0);
    doAccess(memWrite, 3'b010, `LSU_BUS_BASE + 32'h1, 32'h1234_5678);
    doAccess(memRead, 3'b010, 32'h0000_0100, 32'h0);
    doAccess(memWrite, 3'b010, 32'hf000_0000, 32'hcafe_f00d);
    // the targeted words must still hold their old contents
    doAccess(memRead, 3'b010, `LSU_DTIM_BASE, 32'h0);
    doAccess(memRead, 3'b010, `LSU_BUS_BASE, 32'h0);
  endtask

  task automatic randomTest();
    logic [31:0] r;
    for (int i = 0; i < 200; i++) begin
      r = lcgNext();
      randAccess(r[20], r[21] ? memWrite : memRead);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    req = '0;
    reqValid = 1'b0;
    waitCycles = '0;
    cycleCount = 0;
    lastAdr = '0;
    lcgState = 32'h3c94;
    // the bus reference starts from the slave model's address pattern
    // every DTIM word is written before its first load, so that region needs no fill
    for (int i = 0; i < 65536; i++) begin
      a = `LSU_BUS_BASE + 32'(i);
      refBus[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
    end
    @(posedge rstN);
    resetTest();
    dtimLoadTest();
    dtimStoreTest();
    busTest();
    faultTest();
    randomTest();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/wbSlaveModel.sv
// wishbone slave memory model

`default_nettype none

`include "lsu_cfg.svh"

module wbSlaveModel import busPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  wbM2s_t     wbIn,
  output wbS2m_t     wbOut,
  input  logic [2:0] waitCycles
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MemWords = 16384;

  logic [31:0] mem [MemWords];
  logic [2:0]  waitCount;
  logic [31:0] byteAdr;

  // every byte starts from a pattern of its full bus address
  initial begin
    for (int i = 0; i < MemWords; i++) begin
      for (int b = 0; b < 4; b++) begin
        byteAdr = `LSU_BUS_BASE + 32'(4 * i + b);
        mem[i][8*b +: 8] = byteAdr[7:0] ^ byteAdr[15:8] ^ byteAdr[23:16] ^ 8'h5a;
      end
    end
  end

  // ack comes after waitCycles idle cycles and lasts one cycle
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbOut.ack <= 1'b0;
      wbOut.dat <= '0;
      waitCount <= '0;
    end else begin
      wbOut.ack <= 1'b0;
      if (wbIn.cyc && wbIn.stb && !wbOut.ack) begin
        if (waitCount >= waitCycles) begin
          wbOut.ack <= 1'b1;
          waitCount <= '0;
          if (wbIn.we) begin
            for (int b = 0; b < 4; b++) begin
              if (wbIn.sel[b]) begin
                mem[wbIn.adr[15:2]][8*b +: 8] <= wbIn.dat[8*b +: 8];
              end
            end
          end else begin
            wbOut.dat <= mem[wbIn.adr[15:2]];
          end
        end else begin
          waitCount <= waitCount + 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/lsuPkg.sv
src/busPkg.sv
src/storeAlign.sv
src/loadExtract.sv
src/dtim.sv
src/wbMaster.sv
src/lsu.sv
testbench/clockGen.sv
testbench/wbSlaveModel.sv
testbench/lsuTb.sv
